/* src.f */
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_burst_counter.sv
rtl/cache_miss_fsm.sv
rtl/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: cache

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/cache_tag_store.sv
      - rtl/cache_data_store.sv
      - rtl/cache_burst_counter.sv
      - rtl/cache_miss_fsm.sv
      - rtl/cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/mem_model.sv
      - bench/cache_tb.sv

/* bench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int          num_tests       = 5;
  localparam int          cycles_per_test = 400;
  localparam int          wait_limit      = 200;
  localparam cache_word_t marker          = 32'h5A5A0000;

  logic        clk;
  logic        reset;
  cache_req_t  req;
  logic        req_v;
  logic        req_ready;
  logic        resp_v;
  cache_word_t resp_data;
  mem_pkt_t    mem_pkt;
  logic        mem_pkt_v;
  logic        mem_pkt_yumi;
  cache_word_t mem_wdata;
  logic        mem_wdata_v;
  logic        mem_wdata_yumi;
  cache_word_t mem_rdata;
  logic        mem_rdata_v;

  int          errors;
  int          checks;
  logic        ready_at_resp;
  mem_pkt_t    pkt_q[$];
  cache_word_t wdata_q[$];

  cache_top DUT (
    .clk_i           (clk),
    .reset_i         (reset),
    .req_i           (req),
    .req_v_i         (req_v),
    .req_ready_o     (req_ready),
    .resp_v_o        (resp_v),
    .resp_data_o     (resp_data),
    .mem_pkt_o       (mem_pkt),
    .mem_pkt_v_o     (mem_pkt_v),
    .mem_pkt_yumi_i  (mem_pkt_yumi),
    .mem_wdata_o     (mem_wdata),
    .mem_wdata_v_o   (mem_wdata_v),
    .mem_wdata_yumi_i(mem_wdata_yumi),
    .mem_rdata_i     (mem_rdata),
    .mem_rdata_v_i   (mem_rdata_v)
  );

  mem_model u_mem (
    .clk_i           (clk),
    .reset_i         (reset),
    .mem_pkt_i       (mem_pkt),
    .mem_pkt_v_i     (mem_pkt_v),
    .mem_pkt_yumi_o  (mem_pkt_yumi),
    .mem_wdata_i     (mem_wdata),
    .mem_wdata_v_i   (mem_wdata_v),
    .mem_wdata_yumi_o(mem_wdata_yumi),
    .mem_rdata_o     (mem_rdata),
    .mem_rdata_v_o   (mem_rdata_v)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // transfers seen mid-cycle complete on the next rising edge
  always @(negedge clk) begin
    if (!reset && mem_pkt_v && mem_pkt_yumi) begin
      pkt_q.push_back(mem_pkt);
    end
    if (!reset && mem_wdata_v && mem_wdata_yumi) begin
      wdata_q.push_back(mem_wdata);
    end
  end

  function automatic cache_word_t rule_word(input cache_addr_t addr);
    cache_addr_t aligned;
    aligned = (addr >> byte_off_w) << byte_off_w;
    return cache_word_t'(aligned) ^ marker;
  endfunction

  function automatic mem_pkt_t block_cmd(input logic write, input cache_addr_t addr);
    mem_pkt_t p;
    p.write = write;
    p.addr  = (addr >> (byte_off_w + word_off_w)) << (byte_off_w + word_off_w);
    return p;
  endfunction

  function automatic cache_req_t make_req(input cache_op_e op, input cache_addr_t addr,
                                          input cache_word_t data, input cache_mask_t mask);
    cache_req_t r;
    r.op           = op;
    r.addr         = addr;
    r.payload.data = data;
    r.mask         = mask;
    return r;
  endfunction

  // tag store data word carries valid, way and tag
  function automatic cache_req_t make_tagst(input cache_addr_t addr, input logic valid,
                                            input cache_way_t way, input cache_tag_t tag);
    cache_req_t r;
    r                     = '0;
    r.op                  = op_tagst;
    r.addr                = addr;
    r.payload.tagst.valid = valid;
    r.payload.tagst.way   = way;
    r.payload.tagst.tag   = tag;
    return r;
  endfunction

  task automatic check_word(input string name, input cache_word_t exp, input cache_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_pkt(input string name, input mem_pkt_t exp, input mem_pkt_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected write=%0b addr=%h, got write=%0b addr=%h",
               $time, name, exp.write, exp.addr, act.write, act.addr);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("[ERROR] %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic expect_pkt(input mem_pkt_t exp);
    if (pkt_q.size() == 0) begin
      errors++;
      $display("%0t: no memory command was seen where one was expected", $time);
    end else begin
      check_pkt("mem_pkt_o", exp, pkt_q.pop_front());
    end
  endtask

  task automatic begin_test(input string name);
    @(posedge clk);
    pkt_q.delete();
    wdata_q.delete();
    $display("test: %s", name);
  endtask

  // latency counts cycles from the accepting edge to the response cycle
  task automatic issue(input cache_req_t r, output cache_word_t resp, output int latency);
    int   waited;
    logic accepted;
    resp    = '0;
    latency = 0;
    waited  = 0;
    @(posedge clk);
    req   <= r;
    req_v <= 1'b1;
    @(negedge clk);
    while (!req_ready && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    accepted = req_ready;
    @(posedge clk);
    req_v <= 1'b0;
    if (!accepted) begin
      errors++;
      $display("%0t: request to %h was not accepted in time", $time, r.addr);
    end else begin
      @(negedge clk);
      latency = 1;
      while (!resp_v && latency < wait_limit) begin
        @(negedge clk);
        latency++;
      end
      if (resp_v) begin
        resp          = resp_data;
        ready_at_resp = req_ready;
      end else begin
        errors++;
        $display("%0t: request to %h got no response", $time, r.addr);
      end
    end
  endtask

  task automatic load_word(input cache_addr_t addr, output cache_word_t data,
                           output int latency);
    issue(make_req(op_load, addr, '0, '0), data, latency);
  endtask

  task automatic store_bytes(input cache_addr_t addr, input cache_word_t data,
                             input cache_mask_t mask);
    cache_word_t resp;
    int          latency;
    issue(make_req(op_store, addr, data, mask), resp, latency);
    check_word("resp_data_o", '0, resp);
  endtask

  task automatic load_miss_then_hit();
    cache_word_t data;
    int          latency;
    begin_test("load miss then hit");
    check_count("req_ready_o after reset", 1, req_ready);
    load_word(16'h1014, data, latency);
    check_word("resp_data_o", rule_word(16'h1014), data);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1010));
    load_word(16'h1018, data, latency);
    check_word("resp_data_o", rule_word(16'h1018), data);
    check_count("memory commands", 0, pkt_q.size());
    check_count("hit latency", 1, latency);
    check_count("req_ready_o in response cycle", 0, ready_at_resp);
    @(negedge clk);
    check_count("req_ready_o after response", 1, req_ready);
    check_count("resp_v_o after response", 0, resp_v);
  endtask

  task automatic store_merge();
    cache_word_t data;
    cache_word_t exp_word;
    int          latency;
    begin_test("store merge");
    store_bytes(16'h2024, 32'hAABBCCDD, 4'b0101);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h2020));
    // bytes 0 and 2 come from the store, 1 and 3 keep the memory word
    exp_word        = rule_word(16'h2024);
    exp_word[7:0]   = 8'hDD;
    exp_word[23:16] = 8'hBB;
    load_word(16'h2024, data, latency);
    check_word("resp_data_o", exp_word, data);
    check_count("hit latency", 1, latency);
  endtask

  // a, b, a, then c must push out b
  task automatic lru_replacement();
    cache_word_t data;
    int          latency;
    begin_test("lru replacement");
    load_word(16'h1030, data, latency);
    load_word(16'h2030, data, latency);
    load_word(16'h1030, data, latency);
    check_count("hit latency", 1, latency);
    check_count("memory commands", 2, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1030));
    expect_pkt(block_cmd(1'b0, 16'h2030));
    load_word(16'h3034, data, latency);
    check_word("resp_data_o", rule_word(16'h3034), data);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h3030));
    load_word(16'h1038, data, latency);
    check_word("resp_data_o", rule_word(16'h1038), data);
    check_count("hit latency", 1, latency);
    check_count("memory commands", 0, pkt_q.size());
    load_word(16'h2030, data, latency);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h2030));
  endtask

  task automatic dirty_writeback();
    cache_word_t data;
    cache_word_t wb_exp [`CACHE_BLOCK_WORDS];
    int          latency;
    begin_test("dirty write-back");
    store_bytes(16'h1044, 32'h11223344, 4'b1111);
    store_bytes(16'h104C, 32'hCAFEF00D, 4'b0011);
    load_word(16'h2040, data, latency);
    check_count("memory commands", 2, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1040));
    expect_pkt(block_cmd(1'b0, 16'h2040));
    // lru now points at the dirty block
    load_word(16'h3048, data, latency);
    check_word("resp_data_o", rule_word(16'h3048), data);
    check_count("memory commands", 2, pkt_q.size());
    expect_pkt(block_cmd(1'b1, 16'h1040));
    expect_pkt(block_cmd(1'b0, 16'h3040));
    wb_exp[0]        = rule_word(16'h1040);
    wb_exp[1]        = 32'h11223344;
    wb_exp[2]        = rule_word(16'h1048);
    wb_exp[3]        = rule_word(16'h104C);
    wb_exp[3][15:0]  = 16'hF00D;
    check_count("write-back words", `CACHE_BLOCK_WORDS, wdata_q.size());
    for (int i = 0; i < `CACHE_BLOCK_WORDS; i++) begin
      if (i < wdata_q.size()) begin
        check_word("mem_wdata_o", wb_exp[i], wdata_q[i]);
      end
    end
    load_word(16'h1044, data, latency);
    check_word("resp_data_o", wb_exp[1], data);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1040));
    load_word(16'h104C, data, latency);
    check_word("resp_data_o", wb_exp[3], data);
  endtask

  task automatic tag_store_invalidate();
    cache_word_t data;
    int          latency;
    begin_test("tag store invalidate");
    store_bytes(16'h1054, 32'h0BADBEEF, 4'b1111);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1050));
    issue(make_tagst(16'h1050, 1'b0, 1'b0, 8'h10), data, latency);
    check_word("resp_data_o", '0, data);
    check_count("tag store latency", 1, latency);
    check_count("memory commands", 0, pkt_q.size());
    // dirty data is dropped, so the reload sees the memory word
    load_word(16'h1054, data, latency);
    check_word("resp_data_o", rule_word(16'h1054), data);
    check_count("memory commands", 1, pkt_q.size());
    expect_pkt(block_cmd(1'b0, 16'h1050));
    check_count("write-back words", 0, wdata_q.size());
  endtask

  initial begin
    repeat (num_tests * cycles_per_test) @(posedge clk);
    $display("watchdog: tests did not finish within %0d cycles", num_tests * cycles_per_test);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    errors        = 0;
    checks        = 0;
    ready_at_resp = 1'b0;
    reset         = 1'b1;
    req_v         = 1'b0;
    req           = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    load_miss_then_hit();
    store_merge();
    lru_replacement();
    dirty_writeback();
    tag_store_invalidate();
    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module mem_model (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  cache_pkg::mem_pkt_t    mem_pkt_i,
  input  logic                   mem_pkt_v_i,
  output logic                   mem_pkt_yumi_o,
  input  cache_pkg::cache_word_t mem_wdata_i,
  input  logic                   mem_wdata_v_i,
  output logic                   mem_wdata_yumi_o,
  output cache_pkg::cache_word_t mem_rdata_o,
  output logic                   mem_rdata_v_o
);
  import cache_pkg::*;

  localparam int          depth     = 1 << (`CACHE_ADDR_WIDTH - byte_off_w);
  localparam int unsigned rand_seed = 10748;

  typedef enum logic [2:0] {
    m_idle,
    m_wait,
    m_accept,
    m_read,
    m_write
  } model_state_e;

  cache_word_t  mem_q [depth];
  model_state_e state;
  int           wait_cnt;
  int           word_cnt;
  int           base;
  int unsigned  pick;
  bit           seeded;

  // each word starts as its own byte address xor a marker
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem_q[i] = cache_word_t'(i << byte_off_w) ^ 32'h5A5A0000;
    end
    mem_pkt_yumi_o   = 1'b0;
    mem_wdata_yumi_o = 1'b0;
    mem_rdata_o      = '0;
    mem_rdata_v_o    = 1'b0;
    state            = m_idle;
    seeded           = 1'b0;
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      if (!seeded) begin
        pick   = $urandom(rand_seed);
        seeded = 1'b1;
      end
      mem_pkt_yumi_o   <= 1'b0;
      mem_wdata_yumi_o <= 1'b0;
      mem_rdata_v_o    <= 1'b0;
      state            <= m_idle;
    end else begin
      case (state)
        // take the command after 0 to 3 extra cycles
        m_idle: begin
          if (mem_pkt_v_i) begin
            pick = $urandom % 4;
            if (pick == 0) begin
              mem_pkt_yumi_o <= 1'b1;
              state          <= m_accept;
            end else begin
              wait_cnt <= pick;
              state    <= m_wait;
            end
          end
        end
        m_wait: begin
          if (wait_cnt == 1) begin
            mem_pkt_yumi_o <= 1'b1;
            state          <= m_accept;
          end else begin
            wait_cnt <= wait_cnt - 1;
          end
        end
        m_accept: begin
          mem_pkt_yumi_o <= 1'b0;
          base           <= mem_pkt_i.addr >> byte_off_w;
          if (mem_pkt_i.write) begin
            word_cnt         <= 0;
            mem_wdata_yumi_o <= 1'b1;
            state            <= m_write;
          end else begin
            mem_rdata_o   <= mem_q[mem_pkt_i.addr >> byte_off_w];
            mem_rdata_v_o <= 1'b1;
            word_cnt      <= 1;
            state         <= m_read;
          end
        end
        // fill words go out back to back
        m_read: begin
          if (word_cnt == `CACHE_BLOCK_WORDS) begin
            mem_rdata_v_o <= 1'b0;
            state         <= m_idle;
          end else begin
            mem_rdata_o <= mem_q[base + word_cnt];
            word_cnt    <= word_cnt + 1;
          end
        end
        m_write: begin
          if (mem_wdata_v_i) begin
            mem_q[base + word_cnt] <= mem_wdata_i;
            word_cnt               <= word_cnt + 1;
            if (word_cnt == `CACHE_BLOCK_WORDS - 1) begin
              mem_wdata_yumi_o <= 1'b0;
              state            <= m_idle;
            end
          end
        end
        default: begin
          state <= m_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  cache_pkg::cache_req_t  req_i,
  input  logic                   req_v_i,
  output logic                   req_ready_o,
  output logic                   resp_v_o,
  output cache_pkg::cache_word_t resp_data_o,
  output cache_pkg::mem_pkt_t    mem_pkt_o,
  output logic                   mem_pkt_v_o,
  input  logic                   mem_pkt_yumi_i,
  output cache_pkg::cache_word_t mem_wdata_o,
  output logic                   mem_wdata_v_o,
  input  logic                   mem_wdata_yumi_i,
  input  cache_pkg::cache_word_t mem_rdata_i,
  input  logic                   mem_rdata_v_i
);
  import cache_pkg::*;

  cache_req_t       req_q;
  cache_index_t     req_index;
  cache_tag_t       req_tag;
  cache_word_off_t  req_word_off;
  cache_tag_entry_t tagst_entry;

  logic             hit;
  logic             victim_dirty;
  cache_way_t       hit_way;
  cache_way_t       victim_way;
  cache_tag_t       victim_tag;
  logic             cnt_clear;
  logic             cnt_inc;
  logic             cnt_last;
  cache_word_off_t  cnt_offset;
  logic             fill_we;
  logic             store_we;
  logic             tag_we;
  logic             fill_tag_we;
  logic             dirty_set;
  logic             lru_touch;
  logic             burst;
  cache_way_t       data_way;
  cache_word_off_t  data_word_off;
  cache_word_t      rdata;

  // request is held here for the whole lookup and any miss handling
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= '0;
    end else if (req_v_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  assign req_word_off = req_q.addr[byte_off_w +: word_off_w];
  assign req_index    = req_q.addr[byte_off_w + word_off_w +: index_w];
  assign req_tag      = req_q.addr[$bits(cache_addr_t)-1 -: tag_w];

  assign tagst_entry.valid = req_q.payload.tagst.valid;
  assign tagst_entry.tag   = req_q.payload.tagst.tag;

  // bursts address the victim block word by word, otherwise the request word
  assign burst         = mem_wdata_v_o || fill_we;
  assign data_way      = burst ? victim_way : hit_way;
  assign data_word_off = burst ? cnt_offset : req_word_off;

  assign mem_wdata_o = rdata;
  assign resp_data_o = (req_q.op == op_load) ? rdata : '0;

  cache_miss_fsm u_fsm (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_v_i         (req_v_i),
    .req_ready_o     (req_ready_o),
    .op_i            (req_q.op),
    .addr_i          (req_q.addr),
    .hit_i           (hit),
    .victim_dirty_i  (victim_dirty),
    .victim_tag_i    (victim_tag),
    .word_last_i     (cnt_last),
    .mem_pkt_v_o     (mem_pkt_v_o),
    .mem_pkt_o       (mem_pkt_o),
    .mem_pkt_yumi_i  (mem_pkt_yumi_i),
    .mem_wdata_v_o   (mem_wdata_v_o),
    .mem_wdata_yumi_i(mem_wdata_yumi_i),
    .mem_rdata_v_i   (mem_rdata_v_i),
    .cnt_clear_o     (cnt_clear),
    .cnt_inc_o       (cnt_inc),
    .fill_we_o       (fill_we),
    .store_we_o      (store_we),
    .tag_we_o        (tag_we),
    .fill_tag_we_o   (fill_tag_we),
    .dirty_set_o     (dirty_set),
    .lru_touch_o     (lru_touch),
    .resp_v_o        (resp_v_o)
  );

  cache_burst_counter u_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .clear_i (cnt_clear),
    .inc_i   (cnt_inc),
    .offset_o(cnt_offset),
    .last_o  (cnt_last)
  );

  cache_tag_store u_tags (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .index_i       (req_index),
    .tag_i         (req_tag),
    .tag_we_i      (tag_we),
    .tagst_entry_i (tagst_entry),
    .tagst_way_i   (req_q.payload.tagst.way),
    .fill_tag_we_i (fill_tag_we),
    .dirty_set_i   (dirty_set),
    .lru_touch_i   (lru_touch),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way),
    .victim_tag_o  (victim_tag),
    .victim_dirty_o(victim_dirty)
  );

  cache_data_store u_data (
    .clk_i      (clk_i),
    .index_i    (req_index),
    .word_off_i (data_word_off),
    .way_i      (data_way),
    .store_we_i (store_we),
    .mask_i     (req_q.mask),
    .wdata_i    (req_q.payload.data),
    .fill_we_i  (fill_we),
    .fill_data_i(mem_rdata_i),
    .rdata_o    (rdata)
  );

  // one response per request, then straight back to idle
  a_resp_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_v_o |=> (!resp_v_o && (u_fsm.state_q == st_idle)))
    else $error("cache: response longer than one cycle");

  // command and write-back data never share a cycle
  a_mem_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(mem_pkt_v_o && mem_wdata_v_o))
    else $error("cache: memory command and write data valid together");

endmodule

`default_nettype wire

/* rtl/cache_miss_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_miss_fsm (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_v_i,
  output logic                   req_ready_o,
  input  cache_pkg::cache_op_e   op_i,
  input  cache_pkg::cache_addr_t addr_i,
  input  logic                   hit_i,
  input  logic                   victim_dirty_i,
  input  cache_pkg::cache_tag_t  victim_tag_i,
  input  logic                   word_last_i,
  output logic                   mem_pkt_v_o,
  output cache_pkg::mem_pkt_t    mem_pkt_o,
  input  logic                   mem_pkt_yumi_i,
  output logic                   mem_wdata_v_o,
  input  logic                   mem_wdata_yumi_i,
  input  logic                   mem_rdata_v_i,
  output logic                   cnt_clear_o,
  output logic                   cnt_inc_o,
  output logic                   fill_we_o,
  output logic                   store_we_o,
  output logic                   tag_we_o,
  output logic                   fill_tag_we_o,
  output logic                   dirty_set_o,
  output logic                   lru_touch_o,
  output logic                   resp_v_o
);
  import cache_pkg::*;

  localparam int blk_off_w = word_off_w + byte_off_w;

  cache_state_e state_q;
  cache_state_e state_n;
  cache_index_t req_index;
  cache_addr_t  evict_addr;
  cache_addr_t  fill_addr;

  assign req_index  = addr_i[blk_off_w +: index_w];
  assign evict_addr = {victim_tag_i, req_index, {blk_off_w{1'b0}}};
  assign fill_addr  = {addr_i[$bits(cache_addr_t)-1 -: tag_w + index_w], {blk_off_w{1'b0}}};

  // only the write-back command carries the write flag
  assign mem_pkt_o.write = (state_q == st_evict_req);
  assign mem_pkt_o.addr  = (state_q == st_evict_req) ? evict_addr : fill_addr;

  always_comb begin
    state_n       = state_q;
    req_ready_o   = 1'b0;
    resp_v_o      = 1'b0;
    mem_pkt_v_o   = 1'b0;
    mem_wdata_v_o = 1'b0;
    cnt_clear_o   = 1'b0;
    cnt_inc_o     = 1'b0;
    fill_we_o     = 1'b0;
    store_we_o    = 1'b0;
    tag_we_o      = 1'b0;
    fill_tag_we_o = 1'b0;
    dirty_set_o   = 1'b0;
    lru_touch_o   = 1'b0;
    case (state_q)
      st_idle: begin
        req_ready_o = 1'b1;
        if (req_v_i) begin
          state_n = st_lookup;
        end
      end
      st_lookup: begin
        if (op_i == op_tagst) begin
          tag_we_o = 1'b1;
          resp_v_o = 1'b1;
          state_n  = st_idle;
        end else if (hit_i) begin
          resp_v_o    = 1'b1;
          lru_touch_o = 1'b1;
          store_we_o  = (op_i == op_store);
          dirty_set_o = (op_i == op_store);
          state_n     = st_idle;
        end else begin
          state_n = victim_dirty_i ? st_evict_req : st_fill_req;
        end
      end
      st_evict_req: begin
        mem_pkt_v_o = 1'b1;
        if (mem_pkt_yumi_i) begin
          cnt_clear_o = 1'b1;
          state_n     = st_evict_data;
        end
      end
      st_evict_data: begin
        mem_wdata_v_o = 1'b1;
        if (mem_wdata_yumi_i) begin
          cnt_inc_o = 1'b1;
          if (word_last_i) begin
            state_n = st_fill_req;
          end
        end
      end
      st_fill_req: begin
        mem_pkt_v_o = 1'b1;
        if (mem_pkt_yumi_i) begin
          cnt_clear_o = 1'b1;
          state_n     = st_fill_data;
        end
      end
      st_fill_data: begin
        if (mem_rdata_v_i) begin
          fill_we_o = 1'b1;
          cnt_inc_o = 1'b1;
          if (word_last_i) begin
            state_n = st_replay;
          end
        end
      end
      // block is complete, install the tag and retry the access
      st_replay: begin
        fill_tag_we_o = 1'b1;
        state_n       = st_lookup;
      end
      default: begin
        state_n = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_n;
    end
  end

  // lookup needs a known request with a legal opcode in the request register
  a_lookup_has_req: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == st_lookup) |->
      (!$isunknown(addr_i) && (op_i inside {op_load, op_store, op_tagst})))
    else $error("miss fsm: lookup entered without a registered request");

endmodule

`default_nettype wire

/* rtl/cache_burst_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_burst_counter (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       clear_i,
  input  logic                       inc_i,
  output cache_pkg::cache_word_off_t offset_o,
  output logic                       last_o
);
  import cache_pkg::*;

  cache_word_off_t offset_q;

  // wraps back to zero after the last word of a block
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      offset_q <= '0;
    end else if (clear_i) begin
      offset_q <= '0;
    end else if (inc_i) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  assign offset_o = offset_q;
  assign last_o   = (offset_q == cache_word_off_t'(`CACHE_BLOCK_WORDS - 1));

endmodule

`default_nettype wire

/* rtl/cache_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_data_store (
  input  logic                       clk_i,
  input  cache_pkg::cache_index_t    index_i,
  input  cache_pkg::cache_word_off_t word_off_i,
  input  cache_pkg::cache_way_t      way_i,
  input  logic                       store_we_i,
  input  cache_pkg::cache_mask_t     mask_i,
  input  cache_pkg::cache_word_t     wdata_i,
  input  logic                       fill_we_i,
  input  cache_pkg::cache_word_t     fill_data_i,
  output cache_pkg::cache_word_t     rdata_o
);
  import cache_pkg::*;

  cache_word_t blocks_q [`CACHE_WAYS][`CACHE_SETS][`CACHE_BLOCK_WORDS];

  cache_word_t merged;

  assign rdata_o = blocks_q[way_i][index_i][word_off_i];

  // keep the old bytes where the mask is clear
  always_comb begin
    for (int b = 0; b < `CACHE_WORD_WIDTH / 8; b++) begin
      merged[8*b +: 8] = mask_i[b] ? wdata_i[8*b +: 8] : rdata_o[8*b +: 8];
    end
  end

  // fill and store never overlap
  always_ff @(posedge clk_i) begin
    if (fill_we_i) begin
      blocks_q[way_i][index_i][word_off_i] <= fill_data_i;
    end else if (store_we_i) begin
      blocks_q[way_i][index_i][word_off_i] <= merged;
    end
  end

endmodule

`default_nettype wire

/* rtl/cache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tag_store (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  cache_pkg::cache_index_t     index_i,
  input  cache_pkg::cache_tag_t       tag_i,
  input  logic                        tag_we_i,
  input  cache_pkg::cache_tag_entry_t tagst_entry_i,
  input  cache_pkg::cache_way_t       tagst_way_i,
  input  logic                        fill_tag_we_i,
  input  logic                        dirty_set_i,
  input  logic                        lru_touch_i,
  output logic                        hit_o,
  output cache_pkg::cache_way_t       hit_way_o,
  output cache_pkg::cache_way_t       victim_way_o,
  output cache_pkg::cache_tag_t       victim_tag_o,
  output logic                        victim_dirty_o
);
  import cache_pkg::*;

  logic [`CACHE_WAYS-1:0] valid_q [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0] dirty_q [`CACHE_SETS];
  cache_way_t             lru_q   [`CACHE_SETS];
  cache_tag_t             tag_q   [`CACHE_SETS][`CACHE_WAYS];

  logic [`CACHE_WAYS-1:0] hit_vec;
  logic [`CACHE_WAYS-1:0] set_valid;
  logic [`CACHE_WAYS-1:0] set_dirty;

  assign set_valid = valid_q[index_i];
  assign set_dirty = dirty_q[index_i];

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit_vec[w] = set_valid[w] && (tag_q[index_i][w] == tag_i);
    end
  end

  assign hit_o     = |hit_vec;
  assign hit_way_o = hit_vec[1];

  // empty way first, lowest way wins, lru way when the set is full
  always_comb begin
    if (!set_valid[0]) begin
      victim_way_o = 1'b0;
    end else if (!set_valid[1]) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = lru_q[index_i];
    end
  end

  assign victim_tag_o   = tag_q[index_i][victim_way_o];
  assign victim_dirty_o = set_dirty[victim_way_o];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        lru_q[s]   <= '0;
      end
    end else begin
      if (tag_we_i) begin
        valid_q[index_i][tagst_way_i] <= tagst_entry_i.valid;
        dirty_q[index_i][tagst_way_i] <= 1'b0;
      end
      if (fill_tag_we_i) begin
        valid_q[index_i][victim_way_o] <= 1'b1;
        dirty_q[index_i][victim_way_o] <= 1'b0;
      end
      if (dirty_set_i) begin
        dirty_q[index_i][hit_way_o] <= 1'b1;
      end
      // lru bit names the way that was not used last
      if (lru_touch_i) begin
        lru_q[index_i] <= ~hit_way_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_q[index_i][tagst_way_i] <= tagst_entry_i.tag;
    end else if (fill_tag_we_i) begin
      tag_q[index_i][victim_way_o] <= tag_i;
    end
  end

  // fills and tag stores must never leave one tag in both ways of a set
  a_single_hit: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(hit_vec))
    else $error("tag store: address hits more than one way");

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

  // address split, msb to lsb: tag | index | word offset | byte offset
  localparam int byte_off_w = $clog2(`CACHE_WORD_WIDTH / 8);
  localparam int word_off_w = $clog2(`CACHE_BLOCK_WORDS);
  localparam int index_w    = $clog2(`CACHE_SETS);
  localparam int tag_w      = `CACHE_ADDR_WIDTH - index_w - word_off_w - byte_off_w;
  localparam int way_w      = $clog2(`CACHE_WAYS);

  typedef logic [`CACHE_WORD_WIDTH-1:0]   cache_word_t;
  typedef logic [`CACHE_WORD_WIDTH/8-1:0] cache_mask_t;
  typedef logic [`CACHE_ADDR_WIDTH-1:0]   cache_addr_t;
  typedef logic [index_w-1:0]             cache_index_t;
  typedef logic [tag_w-1:0]               cache_tag_t;
  typedef logic [way_w-1:0]               cache_way_t;
  typedef logic [word_off_w-1:0]          cache_word_off_t;

  typedef enum logic [1:0] {
    op_load  = 2'd0,
    op_store = 2'd1,
    op_tagst = 2'd2
  } cache_op_e;

  typedef struct packed {
    logic       valid;
    cache_tag_t tag;
  } cache_tag_entry_t;

  // tag store view of the request data word
  typedef struct packed {
    logic                                               valid;
    cache_way_t                                         way;
    logic [`CACHE_WORD_WIDTH-1-way_w-tag_w-1:0]         pad;
    cache_tag_t                                         tag;
  } cache_tagst_t;

  typedef union packed {
    cache_word_t  data;
    cache_tagst_t tagst;
  } cache_payload_u;

  typedef struct packed {
    cache_op_e      op;
    cache_addr_t    addr;
    cache_payload_u payload;
    cache_mask_t    mask;
  } cache_req_t;

  // block-aligned command on the memory port
  typedef struct packed {
    logic        write;
    cache_addr_t addr;
  } mem_pkt_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict_req,
    st_evict_data,
    st_fill_req,
    st_fill_data,
    st_replay
  } cache_state_e;

endpackage

`default_nettype wire

/* rtl/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// cache geometry
// all sizes are powers of two

// byte address width of the requester and of the memory port
`define CACHE_ADDR_WIDTH 16

// data word width, a whole number of bytes
`define CACHE_WORD_WIDTH 32

// words per block, also the burst length on the memory port
`define CACHE_BLOCK_WORDS 4

// number of sets
`define CACHE_SETS 16

// number of ways
// the replacement logic keeps one lru bit per set, so this stays at 2
`define CACHE_WAYS 2

`endif
